// ==== rtl/stream_reader_defs.svh ====
// Stream reader parameters

`ifndef STREAM_READER_DEFS_SVH
`define STREAM_READER_DEFS_SVH

// SRAM address width, 64 words
`define SR_ADDR_WIDTH 6

// Width of one memory word
`define SR_WORD_WIDTH 64

// Width of one output beat, word width must be a whole multiple of it
`define SR_BEAT_WIDTH 16

// Entries in the prefetch FIFO
`define SR_FIFO_DEPTH 4

`endif

// ==== rtl/stream_reader_pkg.sv ====
// Stream reader types

`include "stream_reader_defs.svh"

package stream_reader_pkg;

    // SRAM word address
    typedef logic [`SR_ADDR_WIDTH-1:0] sram_addr_t;

    // One memory word
    typedef logic [`SR_WORD_WIDTH-1:0] sram_word_t;

    // One output beat
    typedef logic [`SR_BEAT_WIDTH-1:0] beat_t;

    // FIFO occupancy, must also hold the full count
    typedef logic [$clog2(`SR_FIFO_DEPTH + 1)-1:0] fifo_usage_t;

    // Beat position inside a word
    typedef logic [$clog2(`SR_WORD_WIDTH / `SR_BEAT_WIDTH)-1:0] beat_idx_t;

endpackage

// ==== rtl/word_sram.sv ====
// Word memory

`timescale 1ns/1ps

`include "stream_reader_defs.svh"

module word_sram
    import stream_reader_pkg::*;
(
    input  logic       clk_i,
    // Host write port
    input  logic       wr_en_i,
    input  sram_addr_t wr_addr_i,
    input  sram_word_t wr_data_i,
    // Prefetcher read port
    input  logic       rd_en_i,
    input  sram_addr_t rd_addr_i,
    output sram_word_t rd_data_o
);
    localparam int NUM_WORDS = 1 << `SR_ADDR_WIDTH;

    // Storage array, contents undefined until the host loads it
    sram_word_t mem_q [NUM_WORDS];
    sram_word_t rd_data_q;

    // Host writes, only legal while the reader is disabled
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            mem_q[wr_addr_i] <= wr_data_i;
        end
    end

    // One cycle read latency, data held until the next read
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            rd_data_q <= mem_q[rd_addr_i];
        end
    end

    assign rd_data_o = rd_data_q;

endmodule

// ==== rtl/sync_fifo.sv ====
// Synchronous FIFO

`timescale 1ns/1ps

module sync_fifo
    import stream_reader_pkg::*;
#(
    parameter int DEPTH      = 4,
    parameter int DATA_WIDTH = 64
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  flush_i,
    // Write side
    input  logic                  push_i,
    input  logic [DATA_WIDTH-1:0] data_i,
    // Read side, head entry always visible
    input  logic                  pop_i,
    output logic [DATA_WIDTH-1:0] data_o,
    // Status
    output logic                  full_o,
    output logic                  empty_o,
    output logic                  almost_full_o,
    output fifo_usage_t           usage_o
);
    localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [PTR_WIDTH-1:0] LAST_PTR = PTR_WIDTH'(DEPTH - 1);

    // Entry storage
    logic [DATA_WIDTH-1:0] mem_q [DEPTH];

    logic [PTR_WIDTH-1:0] wr_ptr_q;
    logic [PTR_WIDTH-1:0] rd_ptr_q;
    fifo_usage_t          usage_q;

    logic do_push;
    logic do_pop;

    // Status flags from the occupancy count
    assign full_o        = (usage_q == fifo_usage_t'(DEPTH));
    assign empty_o       = (usage_q == '0);
    // One slot kept free for a read already in flight
    assign almost_full_o = (usage_q >= fifo_usage_t'(DEPTH - 1));
    assign usage_o       = usage_q;

    // Illegal requests are dropped here
    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;

    // Not fall-through, head of queue
    assign data_o = mem_q[rd_ptr_q];

    // Entry write
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    // Pointers and count
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            usage_q  <= '0;
        end else if (flush_i) begin
            // Flush drops everything, including a push in the same cycle
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            usage_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
            end
            // Count moves only when exactly one side acts
            case ({do_push, do_pop})
                2'b10:   usage_q <= usage_q + 1'b1;
                2'b01:   usage_q <= usage_q - 1'b1;
                default: usage_q <= usage_q;
            endcase
        end
    end

endmodule

// ==== rtl/mem_to_handshake_fifo.sv ====
// SRAM prefetcher with handshake output

`timescale 1ns/1ps

`include "stream_reader_defs.svh"

module mem_to_handshake_fifo
    import stream_reader_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        en_i,
    input  logic        flush_i,
    // Inclusive last address of the sweep
    input  sram_addr_t  addr_upper_bound_i,
    // SRAM read port
    output logic        mem_ren_o,
    output sram_addr_t  mem_raddr_o,
    input  sram_word_t  mem_rdata_i,
    // Word handshake to the splitter
    input  logic        data_ready_i,
    output logic        data_valid_o,
    output sram_word_t  data_o,
    // Debug occupancy
    output fifo_usage_t fifo_usage_o
);
    sram_addr_t raddr_q;
    sram_addr_t raddr_d;
    logic       ren;
    // Read issued last cycle, its data lands now
    logic       ren_dly_q;
    logic       fifo_empty;
    logic       fifo_almost_full;
    logic       fifo_pop;

    // Stop reading early enough to leave room for the read in flight
    assign ren         = en_i & ~flush_i & ~fifo_almost_full;
    assign mem_ren_o   = ren;
    assign mem_raddr_o = raddr_q;

    // Circular sweep 0 .. bound
    assign raddr_d = (raddr_q == addr_upper_bound_i) ? '0 : sram_addr_t'(raddr_q + 1'b1);

    assign data_valid_o = en_i & ~fifo_empty;
    assign fifo_pop     = data_valid_o & data_ready_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            raddr_q   <= '0;
            ren_dly_q <= 1'b0;
        end else if (flush_i) begin
            // Restart at 0 and cancel the pending push
            raddr_q   <= '0;
            ren_dly_q <= 1'b0;
        end else begin
            ren_dly_q <= ren;
            if (ren) begin
                raddr_q <= raddr_d;
            end
        end
    end

    // Prefetch buffer, full flag not needed thanks to almost-full gating
    sync_fifo #(
        .DEPTH      (`SR_FIFO_DEPTH),
        .DATA_WIDTH (`SR_WORD_WIDTH)
    ) u_fifo (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .push_i        (ren_dly_q),
        .data_i        (mem_rdata_i),
        .pop_i         (fifo_pop),
        .data_o        (data_o),
        .full_o        (),
        .empty_o       (fifo_empty),
        .almost_full_o (fifo_almost_full),
        .usage_o       (fifo_usage_o)
    );

endmodule

// ==== rtl/beat_splitter.sv ====
// Word to beat splitter

`timescale 1ns/1ps

`include "stream_reader_defs.svh"

module beat_splitter
    import stream_reader_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       flush_i,
    // Word handshake in
    input  logic       word_valid_i,
    input  sram_word_t word_data_i,
    output logic       word_ready_o,
    // Beat handshake out
    output logic       out_valid_o,
    output beat_t      out_data_o,
    output logic       out_last_o,
    input  logic       out_ready_i
);
    localparam int BEATS_PER_WORD = `SR_WORD_WIDTH / `SR_BEAT_WIDTH;
    localparam beat_idx_t LAST_IDX = beat_idx_t'(BEATS_PER_WORD - 1);

    // Held word, payload only
    sram_word_t word_q;
    beat_idx_t  idx_q;
    logic       full_q;

    logic beat_fire;
    logic word_fire;

    assign out_valid_o = full_q;
    // LSB first
    assign out_data_o  = word_q[idx_q * `SR_BEAT_WIDTH +: `SR_BEAT_WIDTH];
    assign out_last_o  = full_q & (idx_q == LAST_IDX);

    assign beat_fire = out_valid_o & out_ready_i;

    // Take a new word when empty or when the last beat leaves now
    assign word_ready_o = ~flush_i & (~full_q | (beat_fire & out_last_o));
    assign word_fire    = word_valid_i & word_ready_o;

    // Payload capture
    always_ff @(posedge clk_i) begin
        if (word_fire) begin
            word_q <= word_data_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            full_q <= 1'b0;
            idx_q  <= '0;
        end else if (flush_i) begin
            full_q <= 1'b0;
            idx_q  <= '0;
        end else if (word_fire) begin
            // Back-to-back load, beat 0 next cycle
            full_q <= 1'b1;
            idx_q  <= '0;
        end else if (beat_fire) begin
            if (out_last_o) begin
                full_q <= 1'b0;
                idx_q  <= '0;
            end else begin
                idx_q <= idx_q + 1'b1;
            end
        end
    end

endmodule

// ==== rtl/mem_stream_reader.sv ====
// Memory stream reader top

`timescale 1ns/1ps

module mem_stream_reader
    import stream_reader_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_n_i,
    // Reader control
    input  logic        en_i,
    input  logic        flush_i,
    input  sram_addr_t  addr_upper_bound_i,
    // Host load port, only while en_i is low
    input  logic        wr_en_i,
    input  sram_addr_t  wr_addr_i,
    input  sram_word_t  wr_data_i,
    // Beat stream out
    output logic        out_valid_o,
    output beat_t       out_data_o,
    output logic        out_last_o,
    input  logic        out_ready_i,
    // Debug observation of the prefetch buffer
    output fifo_usage_t fifo_usage_o
);
    // SRAM read path
    logic       mem_ren;
    sram_addr_t mem_raddr;
    sram_word_t mem_rdata;

    // Word handshake between prefetcher and splitter
    logic       word_valid;
    logic       word_ready;
    sram_word_t word_data;

    // Data store
    word_sram u_sram (
        .clk_i     (clk_i),
        .wr_en_i   (wr_en_i),
        .wr_addr_i (wr_addr_i),
        .wr_data_i (wr_data_i),
        .rd_en_i   (mem_ren),
        .rd_addr_i (mem_raddr),
        .rd_data_o (mem_rdata)
    );

    // Circular reads into the prefetch FIFO
    mem_to_handshake_fifo u_prefetch (
        .clk_i              (clk_i),
        .rst_n_i            (rst_n_i),
        .en_i               (en_i),
        .flush_i            (flush_i),
        .addr_upper_bound_i (addr_upper_bound_i),
        .mem_ren_o          (mem_ren),
        .mem_raddr_o        (mem_raddr),
        .mem_rdata_i        (mem_rdata),
        .data_ready_i       (word_ready),
        .data_valid_o       (word_valid),
        .data_o             (word_data),
        .fifo_usage_o       (fifo_usage_o)
    );

    // Words cut into beats
    beat_splitter u_splitter (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .word_valid_i (word_valid),
        .word_data_i  (word_data),
        .word_ready_o (word_ready),
        .out_valid_o  (out_valid_o),
        .out_data_o   (out_data_o),
        .out_last_o   (out_last_o),
        .out_ready_i  (out_ready_i)
    );

endmodule

// ==== tests/mem_stream_reader_checker.sv ====
// Stream reader assertions

`timescale 1ns/1ps

`include "stream_reader_defs.svh"

module mem_stream_reader_checker
    import stream_reader_pkg::*;
(
    input logic        clk_i,
    input logic        rst_n_i,
    input logic        flush_i,
    input logic        out_valid_i,
    input beat_t       out_data_i,
    input logic        out_ready_i,
    input fifo_usage_t fifo_usage_i,
    // Prefetch FIFO internals
    input logic        fifo_push_i,
    input logic        fifo_full_i
);
    // Offered beat held with the same data until taken
    a_beat_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        out_valid_i && !out_ready_i && !flush_i |=> out_valid_i && $stable(out_data_i))
        else $error("beat withdrawn or changed before ready");

    // Occupancy bounded by the FIFO depth
    a_usage_max: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        fifo_usage_i <= fifo_usage_t'(`SR_FIFO_DEPTH))
        else $error("FIFO usage %0d above depth", fifo_usage_i);

    // Flush clears the splitter
    a_flush_clear: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        flush_i |=> !out_valid_i)
        else $error("out_valid_o high right after a flush");

    // Almost-full gating must keep pushes away from a full FIFO
    a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(fifo_push_i && fifo_full_i))
        else $error("push into a full FIFO");

endmodule

bind mem_stream_reader mem_stream_reader_checker u_checker (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .out_valid_i  (out_valid_o),
    .out_data_i   (out_data_o),
    .out_ready_i  (out_ready_i),
    .fifo_usage_i (fifo_usage_o),
    .fifo_push_i  (u_prefetch.u_fifo.push_i),
    .fifo_full_i  (u_prefetch.u_fifo.full_o)
);

// ==== tests/mem_stream_reader_tb.sv ====
// Stream reader testbench

`timescale 1ns/1ps

`include "stream_reader_defs.svh"

module mem_stream_reader_tb
    import stream_reader_pkg::*;
();
    localparam int BEATS = `SR_WORD_WIDTH / `SR_BEAT_WIDTH;
    localparam int NUM_WORDS = 1 << `SR_ADDR_WIDTH;

    logic        clk_i;
    logic        rst_n_i;
    logic        en_i;
    logic        flush_i;
    sram_addr_t  addr_upper_bound_i;
    logic        wr_en_i;
    sram_addr_t  wr_addr_i;
    sram_word_t  wr_data_i;
    logic        out_valid_o;
    beat_t       out_data_o;
    logic        out_last_o;
    logic        out_ready_i;
    fifo_usage_t fifo_usage_o;

    // Reference model state
    sram_word_t model_mem [NUM_WORDS];
    sram_addr_t exp_addr;
    int         beat_idx;
    beat_t      exp_beat;
    logic       exp_last;
    // Flush seen at the previous sample
    logic       flush_seen;

    int    err_cnt;
    int    beat_cnt;
    // 0 ready low, 1 ready high, 2 random
    int    ready_mode;
    string test_name;
    int    bound_sel;

    mem_stream_reader u_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // One cycle with inputs changed 1 ns after the edge
    task automatic step();
        @(posedge clk_i);
        #1;
        case (ready_mode)
            0:       out_ready_i = 1'b0;
            1:       out_ready_i = 1'b1;
            default: out_ready_i = ($urandom & 32'd1) != 0;
        endcase
    endtask

    task automatic wait_beats(input int n, input int limit);
        int target;
        int cycles;
        target = beat_cnt + n;
        cycles = 0;
        while (beat_cnt < target && cycles < limit) begin
            step();
            cycles++;
        end
        if (beat_cnt < target) begin
            err_cnt++;
            $display("%s: timed out with %0d of %0d beats", test_name,
                     n - (target - beat_cnt), n);
        end
    endtask

    // Splitter drains its held word
    task automatic wait_idle(input int limit);
        int cycles;
        cycles = 0;
        while (out_valid_o && cycles < limit) begin
            step();
            cycles++;
        end
        if (out_valid_o) begin
            err_cnt++;
            $display("%s: output never went idle", test_name);
        end
    endtask

    task automatic load_memory();
        for (int a = 0; a < NUM_WORDS; a++) begin
            step();
            wr_en_i   = 1'b1;
            wr_addr_i = sram_addr_t'(a);
            wr_data_i = {$urandom, $urandom};
            model_mem[wr_addr_i] = wr_data_i;
        end
        step();
        wr_en_i = 1'b0;
    endtask

    // Scoreboard sampled mid-cycle where everything is settled
    always @(negedge clk_i) begin
        if (rst_n_i) begin
            if (fifo_usage_o > fifo_usage_t'(`SR_FIFO_DEPTH)) begin
                err_cnt++;
                $display("%s: FIFO usage %0d above depth", test_name, fifo_usage_o);
            end
            // FIFO empty in the cycle after a flush
            if (flush_seen && fifo_usage_o !== '0) begin
                err_cnt++;
                $display("mismatch %s fifo_usage_o after flush: expected 0 actual %0d",
                         test_name, fifo_usage_o);
            end
            if (out_valid_o && out_ready_i) begin
                exp_beat = beat_t'(model_mem[exp_addr] >> (beat_idx * `SR_BEAT_WIDTH));
                exp_last = (beat_idx == BEATS - 1);
                if (out_data_o !== exp_beat) begin
                    err_cnt++;
                    $display("mismatch %s data: expected %h actual %h", test_name,
                             exp_beat, out_data_o);
                end
                if (out_last_o !== exp_last) begin
                    err_cnt++;
                    $display("mismatch %s last: expected %b actual %b", test_name,
                             exp_last, out_last_o);
                end
                beat_cnt++;
                // Next beat and wrap at the bound after the last one
                if (beat_idx == BEATS - 1) begin
                    beat_idx = 0;
                    exp_addr = (exp_addr == addr_upper_bound_i) ? '0
                                                                : sram_addr_t'(exp_addr + 1'b1);
                end else begin
                    beat_idx++;
                end
            end
            if (flush_i) begin
                exp_addr = '0;
                beat_idx = 0;
            end
            flush_seen = flush_i;
        end
    end

    initial begin
        void'($urandom(32'h13c3_d5d9));
        rst_n_i            = 1'b0;
        en_i               = 1'b0;
        flush_i            = 1'b0;
        addr_upper_bound_i = sram_addr_t'(NUM_WORDS - 1);
        wr_en_i            = 1'b0;
        wr_addr_i          = '0;
        wr_data_i          = '0;
        out_ready_i        = 1'b0;
        ready_mode         = 1;
        exp_addr           = '0;
        beat_idx           = 0;
        flush_seen         = 1'b0;
        err_cnt            = 0;
        beat_cnt           = 0;
        test_name          = "reset_state";
        repeat (2) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        if (out_valid_o !== 1'b0) begin
            err_cnt++;
            $display("mismatch %s out_valid_o: expected 0 actual %b", test_name,
                     out_valid_o);
        end
        if (out_last_o !== 1'b0) begin
            err_cnt++;
            $display("mismatch %s out_last_o: expected 0 actual %b", test_name,
                     out_last_o);
        end
        if (fifo_usage_o !== '0) begin
            err_cnt++;
            $display("mismatch %s fifo_usage_o: expected 0 actual %0d", test_name,
                     fifo_usage_o);
        end

        // Full sweep with ready high
        test_name = "load_and_stream";
        load_memory();
        step();
        en_i = 1'b1;
        wait_beats(NUM_WORDS * BEATS, 2000);

        // Smaller bound over three sweeps
        test_name = "wraparound";
        step();
        en_i = 1'b0;
        wait_idle(50);
        bound_sel = int'($urandom_range(62, 0));
        step();
        addr_upper_bound_i = sram_addr_t'(bound_sel);
        flush_i = 1'b1;
        step();
        flush_i = 1'b0;
        en_i    = 1'b1;
        wait_beats(3 * (bound_sel + 1) * BEATS, 3000);

        test_name  = "back_pressure";
        ready_mode = 2;
        wait_beats(300, 3000);

        // Pause mid-stream and resume where it stopped
        test_name = "disable";
        step();
        en_i = 1'b0;
        wait_idle(50);
        repeat (8) begin
            step();
            if (out_valid_o !== 1'b0) begin
                err_cnt++;
                $display("mismatch %s out_valid_o: expected 0 actual %b", test_name,
                         out_valid_o);
            end
        end
        en_i = 1'b1;
        wait_beats(100, 1000);

        // Flush at a random point and restart at address 0
        test_name = "flush";
        repeat ($urandom_range(40, 5)) step();
        ready_mode = 0;
        step();
        flush_i = 1'b1;
        step();
        flush_i    = 1'b0;
        ready_mode = 2;
        wait_beats(120, 1500);

        $display("errors %0d, beats checked %0d", err_cnt, beat_cnt);
        if (err_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== mem_stream_reader.f ====
+incdir+rtl
rtl/stream_reader_pkg.sv
rtl/word_sram.sv
rtl/sync_fifo.sv
rtl/mem_to_handshake_fifo.sv
rtl/beat_splitter.sv
rtl/mem_stream_reader.sv
tests/mem_stream_reader_checker.sv
tests/mem_stream_reader_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the stream reader testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir

verilator --binary --timing --assert \
    --top-module mem_stream_reader_tb \
    --Mdir "$OBJ_DIR" -o mem_stream_reader_sim \
    -f mem_stream_reader.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ_DIR/mem_stream_reader_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The testbench verdict lives in the log
if grep -q "Verification failed" "$LOG"; then
    exit 1
fi
exit 0
